//--- src/rv_core_pkg.sv
// RV32I core package
// Opcodes, funct3 codes, operand selects, the instruction word union
// and the words passed between the pipeline stages
`default_nettype none

package rv_core_pkg;

  typedef enum logic [6:0] {
    RV_OP       = 7'b0110011,
    RV_OP_IMM   = 7'b0010011,
    RV_LUI      = 7'b0110111,
    RV_AUIPC    = 7'b0010111,
    RV_JAL      = 7'b1101111,
    RV_JALR     = 7'b1100111,
    RV_BRANCH   = 7'b1100011,
    RV_MISC_MEM = 7'b0001111,
    RV_SYSTEM   = 7'b1110011
  } rv_opcode_t;

  typedef enum logic [2:0] {
    RV_F3_ADD_SUB = 3'b000,
    RV_F3_SLL     = 3'b001,
    RV_F3_SLT     = 3'b010,
    RV_F3_SLTU    = 3'b011,
    RV_F3_XOR     = 3'b100,
    RV_F3_SR      = 3'b101,
    RV_F3_OR      = 3'b110,
    RV_F3_AND     = 3'b111
  } alu_f3_t;

  // Branch conditions share the funct3 encoding
  localparam alu_f3_t RV_F3_BEQ  = RV_F3_ADD_SUB;
  localparam alu_f3_t RV_F3_BNE  = RV_F3_SLL;
  localparam alu_f3_t RV_F3_BLT  = RV_F3_XOR;
  localparam alu_f3_t RV_F3_BGE  = RV_F3_SR;
  localparam alu_f3_t RV_F3_BLTU = RV_F3_OR;
  localparam alu_f3_t RV_F3_BGEU = RV_F3_AND;

  typedef enum logic [1:0] {
    REG_RF = 2'd0,
    IMM    = 2'd1,
    PC     = 2'd2,
    ZERO   = 2'd3
  } op_sel_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd_addr;
    alu_f3_t     f3;
    logic        sub_sra;
    op_sel_t     rs1_op;
    op_sel_t     rs2_op;
    logic [31:0] imm;
    logic        we_rd;
    logic        jump;
    logic        branch;
    logic        illegal;
    logic        valid;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
  } s_id_ex_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        we_rd;
    logic        illegal;
    logic        valid;
  } s_ex_res_t;

  typedef struct packed {
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        we_rd;
  } s_wb_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        we_rd;
    logic        illegal;
  } s_retire_t;

endpackage

`default_nettype wire

//--- src/register_file.sv
// Integer register file
// 32 x 32 bit, two combinational reads, one write, x0 fixed at zero
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic        clk,
  input  logic        rst_i,
  input  logic [4:0]  rs1_addr_i,
  input  logic [4:0]  rs2_addr_i,
  input  logic [4:0]  rd_addr_i,
  input  logic [31:0] rd_data_i,
  input  logic        we_i,
  output logic [31:0] rs1_data_o,
  output logic [31:0] rs2_data_o
);
  logic [31:0] regs [32];
  logic        wr_en;

  assign wr_en = we_i & (rd_addr_i != 5'd0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wr_en) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  // Write-through so a same-cycle write is seen by decode
  always_comb begin
    if (rs1_addr_i == 5'd0) rs1_data_o = 32'd0;
    else if (wr_en && (rd_addr_i == rs1_addr_i)) rs1_data_o = rd_data_i;
    else rs1_data_o = regs[rs1_addr_i];

    if (rs2_addr_i == 5'd0) rs2_data_o = 32'd0;
    else if (wr_en && (rd_addr_i == rs2_addr_i)) rs2_data_o = rd_data_i;
    else rs2_data_o = regs[rs2_addr_i];
  end

endmodule

`default_nettype wire

//--- src/decode.sv
// Decode stage
// Takes fetched words, tracks the pc, builds the control word
// and reads both operands from the register file
`timescale 1ns/1ps
`default_nettype none

module decode #(
  parameter logic [31:0] PC_RESET = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  fetch_valid_i,
  input  logic [31:0]           fetch_instr_i,
  output logic                  fetch_ready_o,
  input  logic                  jump_i,
  input  logic [31:0]           pc_jump_i,
  input  rv_core_pkg::s_wb_t    wb_i,
  input  logic                  stall_i,
  output rv_core_pkg::s_id_ex_t id_ex_o
);
  rv_core_pkg::instr_u   instr;
  rv_core_pkg::s_id_ex_t id_ex_ff;
  rv_core_pkg::s_id_ex_t next_id_ex;
  logic [31:0]           pc_ff;
  logic [31:0]           rs1_data;
  logic [31:0]           rs2_data;
  logic                  accept;

  assign instr         = fetch_instr_i;
  assign fetch_ready_o = ~stall_i;
  // Word in flight during a redirect is dropped
  assign accept        = fetch_valid_i & ~stall_i & ~jump_i;
  assign id_ex_o       = id_ex_ff;

  always_comb begin
    next_id_ex          = '0;
    next_id_ex.pc       = pc_ff;
    next_id_ex.rs1_addr = instr.r.rs1;
    next_id_ex.rs2_addr = instr.r.rs2;
    next_id_ex.rd_addr  = instr.r.rd;
    next_id_ex.rs1_data = rs1_data;
    next_id_ex.rs2_data = rs2_data;
    next_id_ex.valid    = accept;

    case (rv_core_pkg::rv_opcode_t'(instr.r.opcode))
      rv_core_pkg::RV_OP: begin
        next_id_ex.f3      = rv_core_pkg::alu_f3_t'(instr.r.funct3);
        next_id_ex.sub_sra = instr.r.funct7[5];
        next_id_ex.rs1_op  = rv_core_pkg::REG_RF;
        next_id_ex.rs2_op  = rv_core_pkg::REG_RF;
        next_id_ex.we_rd   = 1'b1;
      end
      rv_core_pkg::RV_OP_IMM: begin
        next_id_ex.f3      = rv_core_pkg::alu_f3_t'(instr.i.funct3);
        // Only srai uses bit 30 here
        next_id_ex.sub_sra = (instr.i.funct3 == 3'b101) & instr.r.funct7[5];
        next_id_ex.rs1_op  = rv_core_pkg::REG_RF;
        next_id_ex.rs2_op  = rv_core_pkg::IMM;
        next_id_ex.imm     = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
        next_id_ex.we_rd   = 1'b1;
      end
      rv_core_pkg::RV_LUI,
      rv_core_pkg::RV_AUIPC: begin
        next_id_ex.f3     = rv_core_pkg::RV_F3_ADD_SUB;
        next_id_ex.rs1_op = (instr.u.opcode == rv_core_pkg::RV_LUI) ?
                            rv_core_pkg::ZERO : rv_core_pkg::PC;
        next_id_ex.rs2_op = rv_core_pkg::IMM;
        next_id_ex.imm    = {instr.u.imm_31_12, 12'd0};
        next_id_ex.we_rd  = 1'b1;
      end
      rv_core_pkg::RV_JAL: begin
        next_id_ex.f3     = rv_core_pkg::RV_F3_ADD_SUB;
        next_id_ex.rs1_op = rv_core_pkg::PC;
        next_id_ex.rs2_op = rv_core_pkg::IMM;
        next_id_ex.imm    = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                             instr.j.imm_11, instr.j.imm_10_1, 1'b0};
        next_id_ex.jump   = 1'b1;
        next_id_ex.we_rd  = 1'b1;
      end
      rv_core_pkg::RV_JALR: begin
        next_id_ex.f3     = rv_core_pkg::RV_F3_ADD_SUB;
        next_id_ex.rs1_op = rv_core_pkg::REG_RF;
        next_id_ex.rs2_op = rv_core_pkg::IMM;
        next_id_ex.imm    = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
        next_id_ex.jump   = 1'b1;
        next_id_ex.we_rd  = 1'b1;
      end
      rv_core_pkg::RV_BRANCH: begin
        next_id_ex.f3     = rv_core_pkg::alu_f3_t'(instr.b.funct3);
        next_id_ex.rs1_op = rv_core_pkg::REG_RF;
        next_id_ex.rs2_op = rv_core_pkg::REG_RF;
        next_id_ex.imm    = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                             instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
        next_id_ex.branch = 1'b1;
      end
      rv_core_pkg::RV_MISC_MEM,
      rv_core_pkg::RV_SYSTEM: begin
        // Retire as no-ops
        next_id_ex.rs1_op = rv_core_pkg::ZERO;
        next_id_ex.rs2_op = rv_core_pkg::ZERO;
      end
      default: begin
        next_id_ex.rs1_op  = rv_core_pkg::ZERO;
        next_id_ex.rs2_op  = rv_core_pkg::ZERO;
        next_id_ex.illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_ff          <= PC_RESET;
      id_ex_ff.valid <= 1'b0;
    end else if (!stall_i) begin
      id_ex_ff <= next_id_ex;
      if (jump_i) begin
        pc_ff <= pc_jump_i;
      end else if (accept) begin
        pc_ff <= pc_ff + 32'd4;
      end
    end
  end

  register_file u_register_file (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_addr_i (instr.r.rs1),
    .rs2_addr_i (instr.r.rs2),
    .rd_addr_i  (wb_i.rd_addr),
    .rd_data_i  (wb_i.rd_data),
    .we_i       (wb_i.we_rd),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

endmodule

`default_nettype wire

//--- src/execute.sv
// Execute stage
// Operand forwarding, ALU, branch compare and the fetch redirect
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  logic                   clk,
  input  logic                   rst_i,
  input  rv_core_pkg::s_id_ex_t  id_ex_i,
  input  rv_core_pkg::s_wb_t     wb_i,
  input  logic                   stall_i,
  output logic                   jump_o,
  output logic [31:0]            pc_jump_o,
  output rv_core_pkg::s_ex_res_t ex_res_o
);
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] sum;
  logic [31:0] alu_out;
  logic        br_cond;
  logic        taken;

  // Result register holds the instruction one ahead
  always_comb begin
    rs1_val = id_ex_i.rs1_data;
    rs2_val = id_ex_i.rs2_data;
    if (wb_i.we_rd && (wb_i.rd_addr != 5'd0) && (wb_i.rd_addr == id_ex_i.rs1_addr)) begin
      rs1_val = wb_i.rd_data;
    end
    if (wb_i.we_rd && (wb_i.rd_addr != 5'd0) && (wb_i.rd_addr == id_ex_i.rs2_addr)) begin
      rs2_val = wb_i.rd_data;
    end
  end

  always_comb begin
    case (id_ex_i.rs1_op)
      rv_core_pkg::REG_RF: op_a = rs1_val;
      rv_core_pkg::IMM:    op_a = id_ex_i.imm;
      rv_core_pkg::PC:     op_a = id_ex_i.pc;
      default:             op_a = 32'd0;
    endcase
    case (id_ex_i.rs2_op)
      rv_core_pkg::REG_RF: op_b = rs2_val;
      rv_core_pkg::IMM:    op_b = id_ex_i.imm;
      rv_core_pkg::PC:     op_b = id_ex_i.pc;
      default:             op_b = 32'd0;
    endcase
  end

  assign sum = op_a + op_b;

  always_comb begin
    case (id_ex_i.f3)
      rv_core_pkg::RV_F3_ADD_SUB: alu_out = id_ex_i.sub_sra ? (op_a - op_b) : sum;
      rv_core_pkg::RV_F3_SLL:     alu_out = op_a << op_b[4:0];
      rv_core_pkg::RV_F3_SLT:     alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
      rv_core_pkg::RV_F3_SLTU:    alu_out = {31'd0, op_a < op_b};
      rv_core_pkg::RV_F3_XOR:     alu_out = op_a ^ op_b;
      rv_core_pkg::RV_F3_SR:
        alu_out = id_ex_i.sub_sra ? 32'($signed(op_a) >>> op_b[4:0]) : (op_a >> op_b[4:0]);
      rv_core_pkg::RV_F3_OR:      alu_out = op_a | op_b;
      default:                    alu_out = op_a & op_b;
    endcase
  end

  always_comb begin
    case (id_ex_i.f3)
      rv_core_pkg::RV_F3_BEQ:  br_cond = (rs1_val == rs2_val);
      rv_core_pkg::RV_F3_BNE:  br_cond = (rs1_val != rs2_val);
      rv_core_pkg::RV_F3_BLT:  br_cond = $signed(rs1_val) < $signed(rs2_val);
      rv_core_pkg::RV_F3_BGE:  br_cond = $signed(rs1_val) >= $signed(rs2_val);
      rv_core_pkg::RV_F3_BLTU: br_cond = rs1_val < rs2_val;
      rv_core_pkg::RV_F3_BGEU: br_cond = rs1_val >= rs2_val;
      default:                 br_cond = 1'b0;
    endcase
  end

  assign taken = id_ex_i.valid & (id_ex_i.jump | (id_ex_i.branch & br_cond));

  assign jump_o    = taken & ~stall_i;
  // Bit 0 cleared for jalr targets
  assign pc_jump_o = id_ex_i.branch ? (id_ex_i.pc + id_ex_i.imm) : {sum[31:1], 1'b0};

  always_comb begin
    ex_res_o.pc      = id_ex_i.pc;
    ex_res_o.rd_addr = id_ex_i.rd_addr;
    ex_res_o.rd_data = id_ex_i.jump ? (id_ex_i.pc + 32'd4) : alu_out;
    ex_res_o.we_rd   = id_ex_i.we_rd;
    ex_res_o.illegal = id_ex_i.illegal;
    ex_res_o.valid   = id_ex_i.valid;
  end

endmodule

`default_nettype wire

//--- src/result.sv
// Result stage
// Retire register, retire port and register write-back
`timescale 1ns/1ps
`default_nettype none

module result (
  input  logic                   clk,
  input  logic                   rst_i,
  input  rv_core_pkg::s_ex_res_t ex_res_i,
  input  logic                   stall_i,
  output rv_core_pkg::s_wb_t     wb_o,
  output logic                   retire_valid_o,
  output rv_core_pkg::s_retire_t retire_o
);
  rv_core_pkg::s_ex_res_t res_ff;

  // Record held until the retire port accepts it
  always_ff @(posedge clk) begin
    if (rst_i) res_ff.valid <= 1'b0;
    else if (!stall_i) res_ff <= ex_res_i;
  end

  assign retire_valid_o = res_ff.valid;

  always_comb begin
    retire_o.pc      = res_ff.pc;
    retire_o.rd_addr = res_ff.rd_addr;
    retire_o.rd_data = res_ff.rd_data;
    retire_o.we_rd   = res_ff.we_rd;
    retire_o.illegal = res_ff.illegal;
  end

  // Write lands in the cycle the record retires
  always_comb begin
    wb_o.rd_addr = res_ff.rd_addr;
    wb_o.rd_data = res_ff.rd_data;
    wb_o.we_rd   = res_ff.valid & res_ff.we_rd & ~res_ff.illegal & ~stall_i;
  end

endmodule

`default_nettype wire

//--- src/rv_core_top.sv
// RV32I three-stage core
// Decode, execute and result stages with an external fetch port
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
  parameter logic [31:0] PC_RESET = 32'h0000_0000
) (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   fetch_valid_i,
  input  logic [31:0]            fetch_instr_i,
  output logic                   fetch_ready_o,
  output logic                   jump_o,
  output logic [31:0]            pc_jump_o,
  output logic                   retire_valid_o,
  output rv_core_pkg::s_retire_t retire_o,
  input  logic                   retire_ready_i
);
  rv_core_pkg::s_id_ex_t  id_ex;
  rv_core_pkg::s_ex_res_t ex_res;
  rv_core_pkg::s_wb_t     wb;

  // Retire back-pressure freezes every stage
  wire stall = ~retire_ready_i;

  decode #(
    .PC_RESET (PC_RESET)
  ) u_decode (
    .clk           (clk),
    .rst_i         (rst_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_ready_o (fetch_ready_o),
    .jump_i        (jump_o),
    .pc_jump_i     (pc_jump_o),
    .wb_i          (wb),
    .stall_i       (stall),
    .id_ex_o       (id_ex)
  );

  execute u_execute (
    .clk       (clk),
    .rst_i     (rst_i),
    .id_ex_i   (id_ex),
    .wb_i      (wb),
    .stall_i   (stall),
    .jump_o    (jump_o),
    .pc_jump_o (pc_jump_o),
    .ex_res_o  (ex_res)
  );

  result u_result (
    .clk            (clk),
    .rst_i          (rst_i),
    .ex_res_i       (ex_res),
    .stall_i        (stall),
    .wb_o           (wb),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

endmodule

`default_nettype wire

//--- bench/rv_core_assertions.sv
// Protocol checks on the core's outside ports
// Bound to the top level of the core
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions (
  input wire logic                   clk,
  input wire logic                   rst_i,
  input wire logic                   jump_o,
  input wire logic                   retire_valid_o,
  input wire logic                   retire_ready_i,
  input wire rv_core_pkg::s_retire_t retire_o
);

  // Redirects are single-cycle pulses
  jump_single: assert property (@(posedge clk) disable iff (rst_i) jump_o |=> !jump_o)
    else $error("jump_o high two cycles in a row");

  retire_hold: assert property (@(posedge clk) disable iff (rst_i)
    retire_valid_o && !retire_ready_i |=> $stable(retire_o))
    else $error("retire_o changed while stalled");

  illegal_no_write: assert property (@(posedge clk) disable iff (rst_i)
    retire_valid_o && retire_o.illegal |-> !retire_o.we_rd)
    else $error("illegal retire with we_rd set");

  quiet_in_reset: assert property (@(posedge clk)
    rst_i && $past(rst_i) |-> !retire_valid_o && !jump_o)
    else $error("valid output during reset");

endmodule

`default_nettype wire

//--- bench/rv_core_tb.sv
// Testbench for the RV32I three-stage core
// Fetch model from an instruction array, in-order ISA model,
// directed tests and a watchdog
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
  localparam logic [31:0] PC_RESET = 32'h0000_0000;
  localparam int MAX_PROG = 64;
  localparam int N_TESTS = 6;
  localparam longint WATCHDOG_NS = N_TESTS * (MAX_PROG * 20 + 20) * 10;

  logic                   clk;
  logic                   rst_i;
  logic                   fetch_valid_i;
  logic [31:0]            fetch_instr_i;
  logic                   fetch_ready_o;
  logic                   jump_o;
  logic [31:0]            pc_jump_o;
  logic                   retire_valid_o;
  rv_core_pkg::s_retire_t retire_o;
  logic                   retire_ready_i;

  logic [31:0]            imem [MAX_PROG];
  int                     prog_len;
  logic [31:0]            model_regs [32];
  rv_core_pkg::s_retire_t exp_q [$];
  logic [31:0]            fetch_pc;
  int                     n_checks;
  int                     n_errors;

  rv_core_top #(
    .PC_RESET (PC_RESET)
  ) u_dut (
    .clk            (clk),
    .rst_i          (rst_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_instr_i  (fetch_instr_i),
    .fetch_ready_o  (fetch_ready_o),
    .jump_o         (jump_o),
    .pc_jump_o      (pc_jump_o),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .retire_ready_i (retire_ready_i)
  );

  bind rv_core_top rv_core_assertions u_rv_core_assertions (
    .clk            (clk),
    .rst_i          (rst_i),
    .jump_o         (jump_o),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_o       (retire_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the core stopped retiring");
    $display("test failed");
    $finish;
  end

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    emit(enc_i(imm, rs1, 3'd0, rd, 7'b0010011));
  endtask

  // Lui plus addi with the upper part rounded for the sign of the low part
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] up;
    up = v + 32'h800;
    emit({up[31:12], rd, 7'b0110111});
    addi(rd, rd, v[11:0]);
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // In-order ISA model that fills the expected retire queue
  task automatic run_model();
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] imm_i;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] next_pc;
    logic        cond;
    rv_core_pkg::s_retire_t rec;
    int steps;
    pc = PC_RESET;
    steps = 0;
    for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;
    exp_q.delete();
    while ((pc < 32'(prog_len * 4)) && (steps < 400)) begin
      w = imem[pc[31:2]];
      imm_i = {{20{w[31]}}, w[31:20]};
      a = model_regs[w[19:15]];
      b = model_regs[w[24:20]];
      next_pc = pc + 32'd4;
      rec = '0;
      rec.pc = pc;
      rec.rd_addr = w[11:7];
      rec.we_rd = 1'b1;
      case (w[6:0])
        7'b0110011: rec.rd_data = alu_ref(w[14:12], w[30], a, b);
        7'b0010011: rec.rd_data = alu_ref(w[14:12], w[30] & (w[14:12] == 3'd5), a, imm_i);
        7'b0110111: rec.rd_data = {w[31:12], 12'd0};
        7'b0010111: rec.rd_data = pc + {w[31:12], 12'd0};
        7'b1101111: begin
          rec.rd_data = pc + 32'd4;
          next_pc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        7'b1100111: begin
          rec.rd_data = pc + 32'd4;
          next_pc = (a + imm_i) & ~32'd1;
        end
        7'b1100011: begin
          rec.we_rd = 1'b0;
          case (w[14:12])
            3'd0: cond = (a == b);
            3'd1: cond = (a != b);
            3'd4: cond = $signed(a) < $signed(b);
            3'd5: cond = $signed(a) >= $signed(b);
            3'd6: cond = a < b;
            3'd7: cond = a >= b;
            default: cond = 1'b0;
          endcase
          if (cond) next_pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        7'b0001111, 7'b1110011: rec.we_rd = 1'b0;
        default: begin
          rec.we_rd = 1'b0;
          rec.illegal = 1'b1;
        end
      endcase
      if (rec.we_rd && (rec.rd_addr != 5'd0)) model_regs[rec.rd_addr] = rec.rd_data;
      exp_q.push_back(rec);
      pc = next_pc;
      steps++;
    end
  endtask

  task automatic compare_retire(input string name, input rv_core_pkg::s_retire_t exp,
                                input rv_core_pkg::s_retire_t act);
    logic bad;
    n_checks++;
    bad = (exp.pc !== act.pc) || (exp.we_rd !== act.we_rd) || (exp.illegal !== act.illegal);
    if (exp.we_rd) begin
      bad = bad || (exp.rd_addr !== act.rd_addr) || (exp.rd_data !== act.rd_data);
    end
    if (bad) begin
      n_errors++;
      $display("error %s: exp pc %h x%0d %h we %b ill %b, got pc %h x%0d %h we %b ill %b",
               name, exp.pc, exp.rd_addr, exp.rd_data, exp.we_rd, exp.illegal,
               act.pc, act.rd_addr, act.rd_data, act.we_rd, act.illegal);
    end
  endtask

  task automatic compare_reg(input string name, input int idx, input logic [31:0] exp,
                             input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error %s: x%0d expected %h, got %h", name, idx, exp, act);
    end
  endtask

  task automatic compare_ready(input string name, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error %s: fetch_ready_o expected %b, got %b", name, exp, act);
    end
  endtask

  // Resets the core, feeds the program and checks every retire
  task automatic run_program(input string name, input bit stall_en);
    int errs_before;
    int drain;
    rv_core_pkg::s_retire_t exp;
    errs_before = n_errors;
    run_model();
    rst_i = 1'b1;
    fetch_valid_i = 1'b0;
    retire_ready_i = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst_i = 1'b0;
    fetch_pc = PC_RESET;
    drain = 0;
    while (drain < 5) begin
      fetch_valid_i = (fetch_pc < 32'(prog_len * 4));
      fetch_instr_i = fetch_valid_i ? imem[fetch_pc[31:2]] : 32'h0000_0013;
      retire_ready_i = (stall_en && exp_q.size() > 0) ? (($urandom % 4) != 0) : 1'b1;
      @(negedge clk);
      // Hazards never hold fetch, only retire back-pressure does
      compare_ready(name, retire_ready_i, fetch_ready_o);
      if (retire_valid_o && retire_ready_i) begin
        if (exp_q.size() == 0) begin
          n_errors++;
          $display("%s: unexpected extra retire at pc %h", name, retire_o.pc);
        end else begin
          exp = exp_q.pop_front();
          compare_retire(name, exp, retire_o);
        end
      end
      if (jump_o) fetch_pc = pc_jump_o;
      else if (fetch_valid_i && fetch_ready_o) fetch_pc = fetch_pc + 32'd4;
      if (exp_q.size() == 0) drain++;
      @(posedge clk);
      #1;
    end
    for (int i = 0; i < 32; i++) begin
      compare_reg(name, i, model_regs[i], u_dut.u_decode.u_register_file.regs[i]);
    end
    $display("%s: finished with %0d errors", name, n_errors - errs_before);
  endtask

  task automatic alu_ops(input string name, input bit stall_en);
    logic [11:0] imm;
    prog_len = 0;
    load_const(5'd1, $urandom);
    load_const(5'd2, $urandom);
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'(4 + f)));
    end
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd12));
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd13));
    for (int f = 0; f < 8; f++) begin
      imm = 12'($urandom);
      if (f == 1 || f == 5) imm = {7'h00, imm[4:0]};
      emit(enc_i(imm, 5'd1, 3'(f), 5'(14 + f), 7'b0010011));
    end
    emit(enc_i({7'h20, 5'($urandom)}, 5'd2, 3'd5, 5'd22, 7'b0010011));
    run_program(name, stall_en);
  endtask

  task automatic dependency_chain();
    prog_len = 0;
    addi(5'd1, 5'd0, 12'd5);
    emit(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
    emit(enc_r(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));
    emit(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));
    emit(enc_r(7'h00, 5'd3, 5'd4, 3'd4, 5'd5));
    emit(enc_r(7'h00, 5'd5, 5'd5, 3'd1, 5'd6));
    addi(5'd6, 5'd6, 12'hfff);
    emit(enc_r(7'h00, 5'd5, 5'd6, 3'd6, 5'd7));
    emit(enc_r(7'h00, 5'd6, 5'd7, 3'd7, 5'd8));
    run_program("dependency_chain", 1'b0);
  endtask

  task automatic control_flow();
    prog_len = 0;
    addi(5'd1, 5'd0, 12'd3);
    addi(5'd2, 5'd0, 12'd3);
    emit(enc_b(13'd8, 5'd2, 5'd1, 3'd0));
    addi(5'd3, 5'd0, 12'd1);
    emit(enc_b(13'd8, 5'd2, 5'd1, 3'd1));
    addi(5'd4, 5'd0, 12'd2);
    emit(enc_j(21'd8, 5'd5));
    addi(5'd6, 5'd0, 12'd9);
    emit({20'd0, 5'd7, 7'b0010111});
    addi(5'd7, 5'd7, 12'd17);
    emit(enc_i(12'd0, 5'd7, 3'd0, 5'd8, 7'b1100111));
    addi(5'd9, 5'd0, 12'd1);
    addi(5'd10, 5'd0, 12'd3);
    addi(5'd10, 5'd10, 12'hfff);
    emit(enc_b(-13'sd4, 5'd0, 5'd10, 3'd1));
    addi(5'd11, 5'd0, 12'hffb);
    emit(enc_b(13'd8, 5'd1, 5'd11, 3'd4));
    addi(5'd12, 5'd0, 12'd1);
    emit(enc_b(13'd8, 5'd1, 5'd11, 3'd7));
    addi(5'd13, 5'd0, 12'd1);
    emit(enc_b(13'd8, 5'd11, 5'd1, 3'd5));
    addi(5'd14, 5'd0, 12'd1);
    emit(enc_b(13'd8, 5'd1, 5'd11, 3'd6));
    addi(5'd15, 5'd0, 12'd7);
    run_program("control_flow", 1'b0);
  endtask

  task automatic upper_and_nops();
    prog_len = 0;
    emit({20'h12345, 5'd1, 7'b0110111});
    emit({20'habcde, 5'd2, 7'b0010111});
    emit(32'h0ff0_000f);
    emit(32'h0000_0073);
    emit({20'($urandom), 5'd3, 7'b0110111});
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd4));
    run_program("upper_and_nops", 1'b0);
  endtask

  task automatic illegal_words();
    prog_len = 0;
    addi(5'd1, 5'd0, 12'd7);
    emit(32'hffff_ffff);
    addi(5'd2, 5'd1, 12'd1);
    emit(32'h0000_0000);
    // Opcode 7f with the rd field pointing at x1
    emit(32'h0000_00ff);
    addi(5'd3, 5'd1, 12'd2);
    run_program("illegal_words", 1'b0);
  endtask

  initial begin
    rst_i = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_instr_i = 32'h0000_0013;
    retire_ready_i = 1'b1;
    n_checks = 0;
    n_errors = 0;
    void'($urandom(32'h2b8a_65e8));
    alu_ops("alu_ops", 1'b0);
    dependency_chain();
    control_flow();
    upper_and_nops();
    illegal_words();
    alu_ops("back_pressure", 1'b1);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
src/rv_core_pkg.sv
src/register_file.sv
src/decode.sv
src/execute.sv
src/result.sv
src/rv_core_top.sv
bench/rv_core_assertions.sv
bench/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= rv_core_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := test failed
PASS_MSG  := test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
